// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing
LINT_FLAGS := --lint-only -Wall --timing
TOP        := alu_tb
RTL_TOP    := alu_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu_core.sv
// LEDs change only on a start pulse; unknown opcodes give a zero result with the illegal flag, no carry or zero flag
`timescale 1ns/1ns

module alu_core (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  alu_pkg::data_t              i_a,
    input  alu_pkg::data_t              i_b,
    input  alu_pkg::op_t                i_op,
    input  logic                        i_start,
    output logic [alu_pkg::LED_W-1:0]   o_led
);

    // Shift amount from the low bits of B
    logic [alu_pkg::SHAMT_W-1:0] shamt;

    // Arithmetic results, 8-bit wrap
    alu_pkg::data_t sum;
    alu_pkg::data_t diff;

    // Signed overflow of each arithmetic path
    logic add_ovf;
    logic sub_ovf;

    // Selected result and flags
    alu_pkg::data_t result;
    logic           ovf;
    logic           illegal;

    // Next LED word
    logic [alu_pkg::LED_W-1:0] led_next;

    assign shamt = i_b[alu_pkg::SHAMT_W-1:0];

    assign sum  = i_a + i_b;
    assign diff = i_a - i_b;

    // ADD overflows when like signs give an unlike result
    assign add_ovf = (i_a[alu_pkg::DATA_W-1] == i_b[alu_pkg::DATA_W-1])
                     && (sum[alu_pkg::DATA_W-1] != i_a[alu_pkg::DATA_W-1]);

    // SUB overflows when unlike signs flip the sign of A
    assign sub_ovf = (i_a[alu_pkg::DATA_W-1] != i_b[alu_pkg::DATA_W-1])
                     && (diff[alu_pkg::DATA_W-1] != i_a[alu_pkg::DATA_W-1]);

    // Operation select
    always_comb
    begin
        result  = '0;
        ovf     = 1'b0;
        illegal = 1'b0;
        case (i_op)
            alu_pkg::OP_ADD:
            begin
                result = sum;
                ovf    = add_ovf;
            end
            alu_pkg::OP_SUB:
            begin
                result = diff;
                ovf    = sub_ovf;
            end
            alu_pkg::OP_AND: result = i_a & i_b;
            alu_pkg::OP_OR:  result = i_a | i_b;
            alu_pkg::OP_XOR: result = i_a ^ i_b;
            alu_pkg::OP_NOR: result = ~(i_a | i_b);
            // Sign fill, i_a is signed
            alu_pkg::OP_SRA: result = i_a >>> shamt;
            // Zero fill
            alu_pkg::OP_SRL: result = $signed($unsigned(i_a) >> shamt);
            default:
            begin
                // Result and overflow stay zero
                illegal = 1'b1;
            end
        endcase
    end

    // Pack result and flags into the LED word
    // Unused upper LEDs stay dark
    always_comb
    begin
        led_next                       = '0;
        led_next[alu_pkg::DATA_W-1:0]  = result;
        led_next[alu_pkg::LED_OVF_BIT] = ovf;
        led_next[alu_pkg::LED_ILL_BIT] = illegal;
    end

    // Output register
    // Holds the last calculation between starts
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_led <= '0;
        else if (i_start)
            o_led <= led_next;
    end

endmodule

// File: alu_pkg.sv
// Shared widths and MIPS function codes; only eight opcodes are legal, and the sizes assume a 16-switch, 16-LED board
package alu_pkg;

    // Datapath and board widths
    localparam int DATA_W  = 8;
    localparam int OP_W    = 6;
    localparam int SW_W    = 16;
    localparam int LED_W   = 16;

    // Shift amount comes from the low bits of B
    localparam int SHAMT_W = 3;

    // Synchronized samples a button must hold before its level flips
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);

    // Terminal count of the debounce counter
    localparam logic [DEBOUNCE_W-1:0] DEBOUNCE_LAST = DEBOUNCE_W'(DEBOUNCE_CYCLES - 1);

    // Operand, result and opcode types
    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic [OP_W-1:0]          op_t;

    // Arithmetic function codes
    localparam op_t OP_ADD = 6'b100000;
    localparam op_t OP_SUB = 6'b100010;

    // Logic function codes
    localparam op_t OP_AND = 6'b100100;
    localparam op_t OP_OR  = 6'b100101;
    localparam op_t OP_XOR = 6'b100110;
    localparam op_t OP_NOR = 6'b100111;

    // Shift function codes
    localparam op_t OP_SRA = 6'b000011;
    localparam op_t OP_SRL = 6'b000010;

    // LED positions of the flags
    // Result occupies bits DATA_W-1..0
    localparam int LED_OVF_BIT = 8;
    localparam int LED_ILL_BIT = 9;

endpackage

// File: alu_tb.sv
// Drives only the board pins; assumes the fixed nine-cycle Op latency and eight-cycle button holds
`timescale 1ns/1ns

module alu_tb;

    // Button timing in clocks
    localparam int HOLD_CYCLES   = 8;
    localparam int SETTLE_CYCLES = 12;
    localparam int LONG_HOLD     = 20;
    localparam int GLITCH_CYCLES = 2;

    // Watchdog budget
    localparam int CYCLES_PER_TEST = 60;
    localparam int WATCHDOG_MARGIN = 100;

    // How a row enters its inputs
    localparam int MODE_FULL   = 0;
    localparam int MODE_OPONLY = 1;
    localparam int MODE_GLITCH = 2;
    localparam int MODE_LONG   = 3;

    // Button selectors
    localparam int BTN_A  = 0;
    localparam int BTN_B  = 1;
    localparam int BTN_OP = 2;

    localparam int SHAMT_MASK = (1 << alu_pkg::SHAMT_W) - 1;

    logic                      i_clock;
    logic                      i_rst_n;
    logic [alu_pkg::SW_W-1:0]  i_sw;
    logic                      i_btn_a;
    logic                      i_btn_b;
    logic                      i_btn_op;
    logic [alu_pkg::LED_W-1:0] o_led;

    // Stimulus table
    string          row_name[$];
    alu_pkg::data_t row_a[$];
    alu_pkg::data_t row_b[$];
    alu_pkg::op_t   row_op[$];
    int             row_mode[$];

    // Bookkeeping
    int error_count;
    int test_errors;
    int tests_run;
    int tests_failed;
    bit table_ready;

    alu_top i_dut (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_sw     (i_sw),
        .i_btn_a  (i_btn_a),
        .i_btn_b  (i_btn_b),
        .i_btn_op (i_btn_op),
        .o_led    (o_led)
    );

    initial i_clock = 1'b0;
    always #5 i_clock = ~i_clock;

    // Reference model from the opcode rules
    function automatic bit is_legal(input alu_pkg::op_t op);
        return op inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_AND, alu_pkg::OP_OR,
                          alu_pkg::OP_XOR, alu_pkg::OP_NOR, alu_pkg::OP_SRA, alu_pkg::OP_SRL};
    endfunction

    // Full-precision value before wrapping to the result width
    function automatic int wide_value(input alu_pkg::data_t a, input alu_pkg::data_t b,
                                      input alu_pkg::op_t op);
        int         sh;
        logic [7:0] ua;
        sh = int'(b) & SHAMT_MASK;
        ua = a;
        case (op)
            alu_pkg::OP_ADD: return int'(a) + int'(b);
            alu_pkg::OP_SUB: return int'(a) - int'(b);
            alu_pkg::OP_AND: return int'(a & b);
            alu_pkg::OP_OR:  return int'(a | b);
            alu_pkg::OP_XOR: return int'(a ^ b);
            alu_pkg::OP_NOR: return int'(~(a | b));
            // Signed int shift keeps the sign
            alu_pkg::OP_SRA: return int'(a) >>> sh;
            // Zero-extended copy of A
            alu_pkg::OP_SRL: return int'(ua) >> sh;
            default:         return 0;
        endcase
    endfunction

    function automatic alu_pkg::data_t expect_result(input alu_pkg::data_t a,
                                                     input alu_pkg::data_t b,
                                                     input alu_pkg::op_t op);
        return alu_pkg::data_t'(wide_value(a, b, op));
    endfunction

    // Overflow means the exact sum or difference leaves the signed range
    function automatic bit expect_overflow(input alu_pkg::data_t a, input alu_pkg::data_t b,
                                           input alu_pkg::op_t op);
        int wide;
        wide = wide_value(a, b, op);
        if (op != alu_pkg::OP_ADD && op != alu_pkg::OP_SUB)
            return 1'b0;
        return (wide > 127) || (wide < -128);
    endfunction

    // Compare tasks
    task automatic check_result(input string name, input alu_pkg::data_t expected,
                                input alu_pkg::data_t actual);
        if (actual !== expected)
        begin
            $display("mismatch %s result expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic expected,
                              input logic actual);
        if (actual !== expected)
        begin
            $display("mismatch %s %s expected %b actual %b", name, what, expected, actual);
            test_errors++;
        end
    endtask

    // All fields of the LED word
    task automatic check_led(input string name, input alu_pkg::data_t exp_res,
                             input logic exp_ovf, input logic exp_ill);
        check_result(name, exp_res, o_led[alu_pkg::DATA_W-1:0]);
        check_flag(name, "overflow", exp_ovf, o_led[alu_pkg::LED_OVF_BIT]);
        check_flag(name, "illegal", exp_ill, o_led[alu_pkg::LED_ILL_BIT]);
        check_flag(name, "upper leds", 1'b0, |o_led[alu_pkg::LED_W-1:alu_pkg::LED_ILL_BIT+1]);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0)
            $display("%s: ok", name);
        else
        begin
            $display("%s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    // Stimulus drivers, all on falling edges
    task automatic set_button(input int which, input logic level);
        case (which)
            BTN_A:   i_btn_a = level;
            BTN_B:   i_btn_b = level;
            default: i_btn_op = level;
        endcase
    endtask

    task automatic press_button(input int which, input logic [alu_pkg::SW_W-1:0] sw,
                                input int high_cycles);
        @(negedge i_clock);
        i_sw = sw;
        set_button(which, 1'b1);
        repeat (high_cycles) @(negedge i_clock);
        set_button(which, 1'b0);
        // Release must debounce too
        repeat (HOLD_CYCLES) @(negedge i_clock);
    endtask

    // Long hold whose switches move once the first press has loaded
    // A second press during the hold would pick up the late value
    task automatic hold_and_change(input int which, input logic [alu_pkg::SW_W-1:0] sw,
                                   input logic [alu_pkg::SW_W-1:0] late_sw,
                                   input int high_cycles);
        @(negedge i_clock);
        i_sw = sw;
        set_button(which, 1'b1);
        repeat (HOLD_CYCLES + 2) @(negedge i_clock);
        i_sw = late_sw;
        repeat (high_cycles - HOLD_CYCLES - 2) @(negedge i_clock);
        set_button(which, 1'b0);
        repeat (HOLD_CYCLES) @(negedge i_clock);
    endtask

    task automatic add_row(input string name, input alu_pkg::data_t a, input alu_pkg::data_t b,
                           input alu_pkg::op_t op, input int mode);
        row_name.push_back(name);
        row_a.push_back(a);
        row_b.push_back(b);
        row_op.push_back(op);
        row_mode.push_back(mode);
    endtask

    task automatic build_table();
        alu_pkg::data_t ra;
        alu_pkg::data_t rb;
        alu_pkg::data_t neg_a;
        for (int i = 0; i < 3; i++)
        begin
            add_row($sformatf("add_rand_%0d", i), alu_pkg::data_t'($urandom),
                    alu_pkg::data_t'($urandom), alu_pkg::OP_ADD, MODE_FULL);
            add_row($sformatf("sub_rand_%0d", i), alu_pkg::data_t'($urandom),
                    alu_pkg::data_t'($urandom), alu_pkg::OP_SUB, MODE_FULL);
        end
        // Overflow corners
        add_row("add_127_1", alu_pkg::data_t'(127), alu_pkg::data_t'(1), alu_pkg::OP_ADD,
                MODE_FULL);
        add_row("sub_m128_1", alu_pkg::data_t'(-128), alu_pkg::data_t'(1), alu_pkg::OP_SUB,
                MODE_FULL);
        add_row("sub_100_m100", alu_pkg::data_t'(100), alu_pkg::data_t'(-100), alu_pkg::OP_SUB,
                MODE_FULL);
        add_row("and_rand", alu_pkg::data_t'($urandom), alu_pkg::data_t'($urandom),
                alu_pkg::OP_AND, MODE_FULL);
        add_row("or_rand", alu_pkg::data_t'($urandom), alu_pkg::data_t'($urandom),
                alu_pkg::OP_OR, MODE_FULL);
        add_row("xor_rand", alu_pkg::data_t'($urandom), alu_pkg::data_t'($urandom),
                alu_pkg::OP_XOR, MODE_FULL);
        add_row("nor_rand", alu_pkg::data_t'($urandom), alu_pkg::data_t'($urandom),
                alu_pkg::OP_NOR, MODE_FULL);
        // Negative A shows sign fill against zero fill
        neg_a = alu_pkg::data_t'(-100);
        add_row("sra_0", neg_a, alu_pkg::data_t'(0), alu_pkg::OP_SRA, MODE_FULL);
        add_row("sra_3", neg_a, alu_pkg::data_t'(3), alu_pkg::OP_SRA, MODE_FULL);
        add_row("sra_7", neg_a, alu_pkg::data_t'(7), alu_pkg::OP_SRA, MODE_FULL);
        add_row("srl_0", neg_a, alu_pkg::data_t'(0), alu_pkg::OP_SRL, MODE_FULL);
        add_row("srl_3", neg_a, alu_pkg::data_t'(3), alu_pkg::OP_SRL, MODE_FULL);
        add_row("srl_7", neg_a, alu_pkg::data_t'(7), alu_pkg::OP_SRL, MODE_FULL);
        // Later rows reuse the operands held since the illegal row
        ra = alu_pkg::data_t'($urandom);
        rb = alu_pkg::data_t'($urandom);
        add_row("illegal_op", ra, rb, 6'b111111, MODE_FULL);
        add_row("reentry_op_only", ra, rb, alu_pkg::OP_ADD, MODE_OPONLY);
        add_row("glitch_on_a", ra, rb, alu_pkg::OP_SUB, MODE_GLITCH);
        add_row("long_op_hold", ra, rb, alu_pkg::OP_XOR, MODE_LONG);
    endtask

    task automatic run_row(input int idx);
        alu_pkg::data_t               exp_res;
        logic                         exp_ovf;
        logic                         exp_ill;
        logic [alu_pkg::SW_W-1:0]     sw_op;
        logic [alu_pkg::SW_W-1:0]     sw_late;
        test_errors = 0;
        exp_res = expect_result(row_a[idx], row_b[idx], row_op[idx]);
        exp_ovf = expect_overflow(row_a[idx], row_b[idx], row_op[idx]);
        exp_ill = !is_legal(row_op[idx]);
        sw_op   = {10'b0, row_op[idx]};
        sw_late = {10'b0, 6'b111111};
        case (row_mode[idx])
            MODE_FULL:
            begin
                press_button(BTN_A, {8'h00, row_a[idx]}, HOLD_CYCLES);
                press_button(BTN_B, {8'h00, row_b[idx]}, HOLD_CYCLES);
                press_button(BTN_OP, sw_op, HOLD_CYCLES);
            end
            MODE_GLITCH:
            begin
                // Short pulse with other switches must not load A
                press_button(BTN_A, {8'h00, ~row_a[idx]}, GLITCH_CYCLES);
                press_button(BTN_OP, sw_op, HOLD_CYCLES);
            end
            // Switches go to an illegal code partway through the hold
            MODE_LONG:  hold_and_change(BTN_OP, sw_op, sw_late, LONG_HOLD);
            default:    press_button(BTN_OP, sw_op, HOLD_CYCLES);
        endcase
        repeat (SETTLE_CYCLES) @(negedge i_clock);
        check_led(row_name[idx], exp_res, exp_ovf, exp_ill);
        if (row_mode[idx] == MODE_LONG)
        begin
            // Second hold with the same inputs leaves the LEDs alone
            press_button(BTN_OP, sw_op, LONG_HOLD);
            repeat (SETTLE_CYCLES) @(negedge i_clock);
            check_led(row_name[idx], exp_res, exp_ovf, exp_ill);
        end
        report_test(row_name[idx]);
    endtask

    // Watchdog sized from the table length
    initial
    begin
        wait (table_ready);
        repeat (row_name.size() * CYCLES_PER_TEST + WATCHDOG_MARGIN) @(posedge i_clock);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        i_rst_n      = 1'b0;
        i_sw         = '0;
        i_btn_a      = 1'b0;
        i_btn_b      = 1'b0;
        i_btn_op     = 1'b0;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'ha116));
        build_table();
        table_ready  = 1'b1;

        // Reset for two cycles, LEDs dark throughout
        repeat (2) @(negedge i_clock);
        check_led("reset", '0, 1'b0, 1'b0);
        i_rst_n = 1'b1;
        @(negedge i_clock);
        check_led("reset", '0, 1'b0, 1'b0);
        report_test("reset");

        for (int i = 0; i < row_name.size(); i++)
            run_row(i);

        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: alu_top.sv
// Buttons are raw and asynchronous; a clean Op press reaches the LEDs after nine clocks, one result at a time
`timescale 1ns/1ns

module alu_top (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic [alu_pkg::SW_W-1:0]    i_sw,
    input  logic                        i_btn_a,
    input  logic                        i_btn_b,
    input  logic                        i_btn_op,
    output logic [alu_pkg::LED_W-1:0]   o_led
);

    // Conditioned press pulses
    logic press_a;
    logic press_b;
    logic press_op;

    // Captured operands and opcode
    alu_pkg::data_t cap_a;
    alu_pkg::data_t cap_b;
    alu_pkg::op_t   cap_op;
    logic           start;

    // One conditioner per button
    button_conditioner u_btn_a (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_btn   (i_btn_a),
        .o_press (press_a)
    );

    button_conditioner u_btn_b (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_btn   (i_btn_b),
        .o_press (press_b)
    );

    button_conditioner u_btn_op (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_btn   (i_btn_op),
        .o_press (press_op)
    );

    // Time-multiplexed switch entry
    operand_capture u_capture (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_sw       (i_sw),
        .i_press_a  (press_a),
        .i_press_b  (press_b),
        .i_press_op (press_op),
        .o_a        (cap_a),
        .o_b        (cap_b),
        .o_op       (cap_op),
        .o_start    (start)
    );

    // Registered ALU driving the LEDs
    alu_core u_alu (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_a     (cap_a),
        .i_b     (cap_b),
        .i_op    (cap_op),
        .i_start (start),
        .o_led   (o_led)
    );

endmodule

// File: button_conditioner.sv
// Raw button is asynchronous; a press counts after DEBOUNCE_CYCLES stable samples and a hold gives one pulse
`timescale 1ns/1ns

module button_conditioner (
    input  logic i_clock,
    input  logic i_rst_n,
    input  logic i_btn,
    output logic o_press
);

    // Two-flop synchronizer chain
    logic btn_meta;
    logic btn_sync;

    // Debounced level and its stability counter
    logic                          btn_level;
    logic [alu_pkg::DEBOUNCE_W-1:0] stable_cnt;

    // Debounced level one cycle late, for edge detection
    logic btn_level_d;

    // Bring the raw input into the clock domain
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end
        else
        begin
            btn_meta <= i_btn;
            btn_sync <= btn_meta;
        end
    end

    // Level flips only after DEBOUNCE_CYCLES consecutive differing samples
    // Any sample that agrees with the level restarts the count
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            btn_level  <= 1'b0;
            stable_cnt <= '0;
        end
        else if (btn_sync == btn_level)
        begin
            // Bounce or idle, start over
            stable_cnt <= '0;
        end
        else if (stable_cnt == alu_pkg::DEBOUNCE_LAST)
        begin
            btn_level  <= btn_sync;
            stable_cnt <= '0;
        end
        else
        begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // One-cycle pulse on the rising debounced level
    // A long hold keeps the level high and pulses once
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            btn_level_d <= 1'b0;
            o_press     <= 1'b0;
        end
        else
        begin
            btn_level_d <= btn_level;
            o_press     <= btn_level && !btn_level_d;
        end
    end

endmodule

// File: operand_capture.sv
// Switch fields are sampled on each press; A and B use the low byte, Op the low six bits, upper switches ignored
`timescale 1ns/1ns

module operand_capture (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic [alu_pkg::SW_W-1:0]    i_sw,
    input  logic                        i_press_a,
    input  logic                        i_press_b,
    input  logic                        i_press_op,
    output alu_pkg::data_t              o_a,
    output alu_pkg::data_t              o_b,
    output alu_pkg::op_t                o_op,
    output logic                        o_start
);

    // Switch fields as seen by each button
    alu_pkg::data_t sw_data;
    alu_pkg::op_t   sw_op;

    assign sw_data = $signed(i_sw[alu_pkg::DATA_W-1:0]);
    assign sw_op   = i_sw[alu_pkg::OP_W-1:0];

    // Operand A register
    // Re-entry allowed at any time
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_a <= '0;
        else if (i_press_a)
            o_a <= sw_data;
    end

    // Operand B register
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_b <= '0;
        else if (i_press_b)
            o_b <= sw_data;
    end

    // Opcode register
    // Loads together with the start request
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_op <= '0;
        else if (i_press_op)
            o_op <= sw_op;
    end

    // Start follows the Op press by one cycle
    // New opcode and held operands are both settled by then
    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_start <= 1'b0;
        else
            o_start <= i_press_op;
    end

endmodule

// File: verilog.f
alu_pkg.sv
button_conditioner.sv
operand_capture.sv
alu_core.sv
alu_top.sv
alu_tb.sv
